// File: verilog/xfer_pkg.sv
// shared types and constants for the data mover
// imported by the CSR block, the sequencer, the storage blocks and the top
`default_nettype none

package xfer_pkg;

   // host operations, encoded as in CTRL bits 1..0
   typedef enum logic [1:0] {
      OP_NONE  = 2'd0,
      OP_FILL  = 2'd1,
      OP_LOAD  = 2'd2,
      OP_STORE = 2'd3
   } xfer_op_e;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RUN,    // issuing accesses
      ST_DRAIN   // last trailing write of load/store
   } seq_state_e;

   localparam int RF_AW      = 5;    // 32 entries, also the block size
   localparam int SRAM_AW    = 8;    // 256 words
   localparam int STORE_BASE = 128;  // store blocks land in upper half
   localparam int DATA_W     = 32;   // default word width

   // register map, byte offsets
   localparam logic [11:0] CTRL_OFS      = 12'h000;  // wo: op, block
   localparam logic [11:0] STATUS_OFS    = 12'h004;  // ro: busy, last op
   localparam logic [11:0] PEEK_ADDR_OFS = 12'h008;  // rw
   localparam logic [11:0] PEEK_DATA_OFS = 12'h00C;  // ro
   localparam logic [11:0] RF_WIN_OFS    = 12'h080;  // 32 word window

endpackage

`default_nettype wire

// File: verilog/reg_file.sv
// 32 entry register file, one write port and two registered read ports
// a read of the entry written in the same cycle gives the old word
`timescale 1ns/1ns
`default_nettype none

module reg_file
   import xfer_pkg::*;
#(
   parameter int DATA_W = xfer_pkg::DATA_W
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              wen,
   input  logic [RF_AW-1:0]  waddr,
   input  logic [DATA_W-1:0] wdata,
   input  logic              re0,
   input  logic [RF_AW-1:0]  raddr0,
   input  logic              re1,
   input  logic [RF_AW-1:0]  raddr1,
   output logic [DATA_W-1:0] rdata0,
   output logic [DATA_W-1:0] rdata1
);

   logic [DATA_W-1:0] mem [2**RF_AW];

   always_ff @(posedge clk) begin
      if (wen)
         mem[waddr] <= wdata;
   end

   // outputs cleared by reset, contents are not
   always_ff @(posedge clk) begin
      if (!rst) begin
         rdata0 <= '0;
         rdata1 <= '0;
      end else begin
         if (re0)
            rdata0 <= mem[raddr0];   // host window port
         if (re1)
            rdata1 <= mem[raddr1];   // store port
      end
   end

endmodule

`default_nettype wire

// File: verilog/block_sram.sv
// single port synchronous SRAM, 256 words
// read data registered and held while en is low
`timescale 1ns/1ns
`default_nettype none

module block_sram
   import xfer_pkg::*;
#(
   parameter int DATA_W = xfer_pkg::DATA_W
) (
   input  logic               clk,
   input  logic               en,
   input  logic               we,
   input  logic [SRAM_AW-1:0] addr,
   input  logic [DATA_W-1:0]  wdata,
   output logic [DATA_W-1:0]  rdata
);

   logic [DATA_W-1:0] mem [2**SRAM_AW];

   always_ff @(posedge clk) begin
      if (en) begin
         if (we)
            mem[addr] <= wdata;
         else
            rdata <= mem[addr];   // rdata untouched on writes
      end
   end

endmodule

`default_nettype wire

// File: verilog/xfer_csr.sv
// AXI4-Lite register block of the data mover
// turns CTRL writes into sequencer commands and serves status, peek and
// register file window reads; one read and one write in flight at a time
`timescale 1ns/1ns
`default_nettype none

module xfer_csr
   import xfer_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic               s_awvalid,
   output logic               s_awready,
   input  logic [11:0]        s_awaddr,
   input  logic               s_wvalid,
   output logic               s_wready,
   input  logic [31:0]        s_wdata,
   input  logic [3:0]         s_wstrb,     // ignored, full word writes only
   output logic               s_bvalid,
   input  logic               s_bready,
   output logic [1:0]         s_bresp,
   input  logic               s_arvalid,
   output logic               s_arready,
   input  logic [11:0]        s_araddr,
   output logic               s_rvalid,
   input  logic               s_rready,
   output logic [31:0]        s_rdata,
   output logic [1:0]         s_rresp,
   output logic               cmd_valid,
   output xfer_op_e           cmd_op,
   output logic [1:0]         cmd_block,
   output logic               peek_req,
   output logic [SRAM_AW-1:0] peek_addr,
   output logic               re0,
   output logic [RF_AW-1:0]   raddr0,
   input  logic               busy,
   input  logic               peek_valid,
   input  logic [DATA_W-1:0]  peek_data,
   input  logic [DATA_W-1:0]  rdata0
);

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   typedef enum logic [1:0] {RD_IDLE, RD_WAIT, RD_RESP} rd_state_e;

   rd_state_e rd_state;
   logic      aw_rdy;        // shared awready/wready pulse
   logic      ar_rdy;
   logic      wr_hs;
   logic      rd_hs;
   logic      wr_ctrl;
   logic      wr_peek_addr;
   logic      ctrl_ok;
   logic      rd_status;
   logic      rd_peek_addr;
   logic      rd_peek_data;
   logic      rd_win;
   logic      wait_rf;       // 1: waiting on reg file, 0: on peek
   xfer_op_e  ctrl_op;
   xfer_op_e  last_op;

   // write side, address and data taken together
   assign s_awready    = aw_rdy;
   assign s_wready     = aw_rdy;
   assign wr_hs        = aw_rdy & s_awvalid & s_wvalid;
   assign wr_ctrl      = (s_awaddr == CTRL_OFS);
   assign wr_peek_addr = (s_awaddr == PEEK_ADDR_OFS);
   assign ctrl_op      = xfer_op_e'(s_wdata[1:0]);
   assign ctrl_ok      = wr_ctrl && (ctrl_op != OP_NONE) && !busy;  // only busy check
   assign cmd_valid    = wr_hs & ctrl_ok;
   assign cmd_op       = ctrl_op;
   assign cmd_block    = s_wdata[3:2];

   always_ff @(posedge clk) begin
      if (!rst) begin
         aw_rdy    <= 1'b0;
         s_bvalid  <= 1'b0;
         last_op   <= OP_NONE;
         peek_addr <= '0;
      end else begin
         // no new write while a response waits on bready
         aw_rdy <= !aw_rdy && s_awvalid && s_wvalid && !s_bvalid;
         if (wr_hs)
            s_bvalid <= 1'b1;
         else if (s_bready)
            s_bvalid <= 1'b0;
         if (cmd_valid)
            last_op <= ctrl_op;
         if (wr_hs && wr_peek_addr)
            peek_addr <= s_wdata[SRAM_AW-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (wr_hs)
         s_bresp <= (ctrl_ok || wr_peek_addr) ? RESP_OKAY : RESP_SLVERR;
   end

   // read side decode
   assign s_arready    = ar_rdy;
   assign s_rvalid     = (rd_state == RD_RESP);
   assign rd_hs        = ar_rdy & s_arvalid;
   assign rd_status    = (s_araddr == STATUS_OFS);
   assign rd_peek_addr = (s_araddr == PEEK_ADDR_OFS);
   assign rd_peek_data = (s_araddr == PEEK_DATA_OFS);
   assign rd_win       = (s_araddr[11:7] == RF_WIN_OFS[11:7]) && (s_araddr[1:0] == 2'b00);
   assign re0          = rd_hs & rd_win;          // data back next cycle
   assign raddr0       = s_araddr[RF_AW+1:2];
   assign peek_req     = rd_hs & rd_peek_data;

   always_ff @(posedge clk) begin
      if (!rst) begin
         rd_state <= RD_IDLE;
         ar_rdy   <= 1'b0;
         wait_rf  <= 1'b0;
      end else begin
         ar_rdy <= (rd_state == RD_IDLE) && s_arvalid && !ar_rdy;
         case (rd_state)
            RD_IDLE: begin
               if (rd_hs) begin
                  wait_rf  <= rd_win;
                  rd_state <= (rd_win || rd_peek_data) ? RD_WAIT : RD_RESP;
               end
            end
            RD_WAIT: begin
               if (wait_rf || peek_valid)   // rf is fixed latency, peek is not
                  rd_state <= RD_RESP;
            end
            RD_RESP: begin
               if (s_rready)
                  rd_state <= RD_IDLE;
            end
            default: rd_state <= RD_IDLE;
         endcase
      end
   end

   // read data and response
   always_ff @(posedge clk) begin
      if (rd_hs) begin
         s_rresp <= RESP_OKAY;
         if (rd_status)
            s_rdata <= {28'd0, last_op, 1'b0, busy};
         else if (rd_peek_addr)
            s_rdata <= {{(32-SRAM_AW){1'b0}}, peek_addr};
         else if (!(rd_win || rd_peek_data)) begin
            s_rdata <= '0;            // unmapped
            s_rresp <= RESP_SLVERR;
         end
      end else if (rd_state == RD_WAIT) begin
         if (wait_rf)
            s_rdata <= rdata0;
         else if (peek_valid)
            s_rdata <= peek_data;
      end
   end

endmodule

`default_nettype wire

// File: verilog/xfer_sequencer.sv
// transfer sequencer, runs fill, load and store between SRAM and register file
// owns the SRAM port and rf write/read1 ports, host peeks get the SRAM when idle
`timescale 1ns/1ns
`default_nettype none

module xfer_sequencer
   import xfer_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic               cmd_valid,
   input  xfer_op_e           cmd_op,
   input  logic [1:0]         cmd_block,
   input  logic               peek_req,
   input  logic [SRAM_AW-1:0] peek_addr,
   input  logic [DATA_W-1:0]  sram_rdata,
   input  logic [DATA_W-1:0]  rf_rdata1,
   output logic               busy,
   output logic               irq,
   output logic               peek_valid,
   output logic [DATA_W-1:0]  peek_data,
   output logic               sram_en,
   output logic               sram_we,
   output logic [SRAM_AW-1:0] sram_addr,
   output logic [DATA_W-1:0]  sram_wdata,
   output logic               rf_wen,
   output logic [RF_AW-1:0]   rf_waddr,
   output logic [DATA_W-1:0]  rf_wdata,
   output logic               rf_re1,
   output logic [RF_AW-1:0]   rf_raddr1
);

   seq_state_e         state;
   xfer_op_e           op;
   logic [1:0]         blk;
   logic [SRAM_AW-1:0] cnt;        // word counter, 8 bits for fill
   logic               wr_pend;    // read in flight, its write is due now
   logic [RF_AW-1:0]   wr_idx;     // block offset of that write
   logic               peek_pend;
   logic [SRAM_AW-1:0] pk_addr;
   logic               serve;      // peek read this cycle
   logic               run;
   logic [SRAM_AW-1:0] ld_addr;
   logic [SRAM_AW-1:0] st_addr;

   assign run     = (state == ST_RUN);
   assign busy    = (state != ST_IDLE);
   assign serve   = peek_pend && (state == ST_IDLE);
   assign ld_addr = SRAM_AW'({blk, cnt[RF_AW-1:0]});                  // 32*b + i
   assign st_addr = SRAM_AW'(STORE_BASE) + SRAM_AW'({blk, wr_idx});  // wraps mod 256

   always_ff @(posedge clk) begin
      if (!rst) begin
         state      <= ST_IDLE;
         op         <= OP_NONE;
         blk        <= '0;
         cnt        <= '0;
         irq        <= 1'b0;
         wr_pend    <= 1'b0;
         peek_pend  <= 1'b0;
         peek_valid <= 1'b0;
      end else begin
         irq        <= 1'b0;
         wr_pend    <= run && (op != OP_FILL);
         peek_valid <= serve;                 // sram data lands next cycle
         if (serve)
            peek_pend <= 1'b0;
         if (peek_req)
            peek_pend <= 1'b1;
         case (state)
            ST_IDLE: begin
               if (cmd_valid) begin
                  state <= ST_RUN;
                  op    <= cmd_op;
                  blk   <= cmd_block;
                  cnt   <= '0;
               end
            end
            ST_RUN: begin
               cnt <= cnt + 1'b1;
               if (op == OP_FILL && cnt == '1) begin
                  state <= ST_IDLE;           // no trailing write for fill
                  irq   <= 1'b1;
               end else if (op != OP_FILL && cnt[RF_AW-1:0] == '1)
                  state <= ST_DRAIN;
            end
            ST_DRAIN: begin
               state <= ST_IDLE;
               irq   <= 1'b1;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // payload, no reset
   always_ff @(posedge clk) begin
      wr_idx <= cnt[RF_AW-1:0];
      if (peek_req)
         pk_addr <= peek_addr;
   end

   assign peek_data = sram_rdata;

   // register file side
   assign rf_re1    = run && (op == OP_STORE);
   assign rf_raddr1 = cnt[RF_AW-1:0];
   assign rf_wen    = wr_pend && (op == OP_LOAD);
   assign rf_waddr  = wr_idx;
   assign rf_wdata  = sram_rdata;

   // SRAM port mux, transfers own it while busy
   always_comb begin
      sram_en    = 1'b0;
      sram_we    = 1'b0;
      sram_addr  = pk_addr;
      sram_wdata = rf_rdata1;
      if (run && op == OP_FILL) begin
         sram_en    = 1'b1;
         sram_we    = 1'b1;
         sram_addr  = cnt;
         sram_wdata = ~{{(DATA_W-SRAM_AW){1'b0}}, cnt};   // inverse of address
      end else if (run && op == OP_LOAD) begin
         sram_en   = 1'b1;
         sram_addr = ld_addr;
      end else if (wr_pend && op == OP_STORE) begin
         sram_en   = 1'b1;
         sram_we   = 1'b1;
         sram_addr = st_addr;
      end else if (serve)
         sram_en = 1'b1;       // peek read at pk_addr
   end

endmodule

`default_nettype wire

// File: verilog/xfer_top.sv
// data mover top level, AXI4-Lite slave plus irq
// sets the word width and wires the CSR block, sequencer and both memories
`timescale 1ns/1ns
`default_nettype none

module xfer_top
   import xfer_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        s_awvalid,
   output logic        s_awready,
   input  logic [11:0] s_awaddr,
   input  logic        s_wvalid,
   output logic        s_wready,
   input  logic [31:0] s_wdata,
   input  logic [3:0]  s_wstrb,
   output logic        s_bvalid,
   input  logic        s_bready,
   output logic [1:0]  s_bresp,
   input  logic        s_arvalid,
   output logic        s_arready,
   input  logic [11:0] s_araddr,
   output logic        s_rvalid,
   input  logic        s_rready,
   output logic [31:0] s_rdata,
   output logic [1:0]  s_rresp,
   output logic        irq
);

   // csr to sequencer
   logic               cmd_valid;
   xfer_op_e           cmd_op;
   logic [1:0]         cmd_block;
   logic               busy;
   logic               peek_req;
   logic [SRAM_AW-1:0] peek_addr;
   logic               peek_valid;
   logic [DATA_W-1:0]  peek_data;
   // storage ports
   logic               re0;
   logic [RF_AW-1:0]   raddr0;
   logic [DATA_W-1:0]  rdata0;
   logic               rf_wen;
   logic [RF_AW-1:0]   rf_waddr;
   logic [DATA_W-1:0]  rf_wdata;
   logic               rf_re1;
   logic [RF_AW-1:0]   rf_raddr1;
   logic [DATA_W-1:0]  rf_rdata1;
   logic               sram_en;
   logic               sram_we;
   logic [SRAM_AW-1:0] sram_addr;
   logic [DATA_W-1:0]  sram_wdata;
   logic [DATA_W-1:0]  sram_rdata;

   xfer_csr u_csr (
      .clk        (clk),
      .rst        (rst),
      .s_awvalid  (s_awvalid),
      .s_awready  (s_awready),
      .s_awaddr   (s_awaddr),
      .s_wvalid   (s_wvalid),
      .s_wready   (s_wready),
      .s_wdata    (s_wdata),
      .s_wstrb    (s_wstrb),
      .s_bvalid   (s_bvalid),
      .s_bready   (s_bready),
      .s_bresp    (s_bresp),
      .s_arvalid  (s_arvalid),
      .s_arready  (s_arready),
      .s_araddr   (s_araddr),
      .s_rvalid   (s_rvalid),
      .s_rready   (s_rready),
      .s_rdata    (s_rdata),
      .s_rresp    (s_rresp),
      .cmd_valid  (cmd_valid),
      .cmd_op     (cmd_op),
      .cmd_block  (cmd_block),
      .peek_req   (peek_req),
      .peek_addr  (peek_addr),
      .re0        (re0),
      .raddr0     (raddr0),
      .busy       (busy),
      .peek_valid (peek_valid),
      .peek_data  (peek_data),
      .rdata0     (rdata0)
   );

   xfer_sequencer u_seq (
      .clk        (clk),
      .rst        (rst),
      .cmd_valid  (cmd_valid),
      .cmd_op     (cmd_op),
      .cmd_block  (cmd_block),
      .peek_req   (peek_req),
      .peek_addr  (peek_addr),
      .sram_rdata (sram_rdata),
      .rf_rdata1  (rf_rdata1),
      .busy       (busy),
      .irq        (irq),
      .peek_valid (peek_valid),
      .peek_data  (peek_data),
      .sram_en    (sram_en),
      .sram_we    (sram_we),
      .sram_addr  (sram_addr),
      .sram_wdata (sram_wdata),
      .rf_wen     (rf_wen),
      .rf_waddr   (rf_waddr),
      .rf_wdata   (rf_wdata),
      .rf_re1     (rf_re1),
      .rf_raddr1  (rf_raddr1)
   );

   reg_file #(.DATA_W(DATA_W)) u_rf (
      .clk    (clk),
      .rst    (rst),
      .wen    (rf_wen),
      .waddr  (rf_waddr),
      .wdata  (rf_wdata),
      .re0    (re0),        // host window
      .raddr0 (raddr0),
      .re1    (rf_re1),     // store source
      .raddr1 (rf_raddr1),
      .rdata0 (rdata0),
      .rdata1 (rf_rdata1)
   );

   block_sram #(.DATA_W(DATA_W)) u_sram (
      .clk   (clk),
      .en    (sram_en),
      .we    (sram_we),
      .addr  (sram_addr),
      .wdata (sram_wdata),
      .rdata (sram_rdata)
   );

endmodule

`default_nettype wire

// File: sim/xfer_asserts.sv
// concurrent checks on the data mover, bound into the top level
// covers irq width, register file writes, write response hold and peek service
`timescale 1ns/1ns
`default_nettype none

module xfer_asserts (
   input logic clk,
   input logic rst,
   input logic irq,
   input logic busy,
   input logic rf_wen,
   input logic peek_valid,
   input logic s_bvalid,
   input logic s_bready
);

   irq_one_cycle: assert property (@(posedge clk) disable iff (!rst) irq |=> !irq)
      else $error("irq high for more than one cycle");

   rf_write_busy: assert property (@(posedge clk) disable iff (!rst) rf_wen |-> busy)
      else $error("register file written while sequencer idle");

   // response must wait for the host
   bvalid_hold: assert property (@(posedge clk) disable iff (!rst)
                                 s_bvalid && !s_bready |=> s_bvalid)
      else $error("bvalid dropped before bready");

   peek_idle: assert property (@(posedge clk) disable iff (!rst)
                               peek_valid |-> !$past(busy))   // served on an idle cycle
      else $error("peek served while busy");

endmodule

bind xfer_top xfer_asserts asserts_i (
   .clk        (clk),
   .rst        (rst),
   .irq        (irq),
   .busy       (busy),
   .rf_wen     (rf_wen),
   .peek_valid (peek_valid),
   .s_bvalid   (s_bvalid),
   .s_bready   (s_bready)
);

`default_nettype wire

// File: sim/xfer_tb.sv
// testbench for the data mover, drives the AXI4-Lite slave of xfer_top
// keeps its own model of SRAM and register file and compares every read
// runs fill, load, store, rejected commands and back-pressure scenarios
`timescale 1ns/1ns
`default_nettype none

module xfer_tb
   import xfer_pkg::*;
();

   localparam int         TIMEOUT = 2000;     // cycles per wait loop
   localparam logic [1:0] OKAY    = 2'b00;
   localparam logic [1:0] SLVERR  = 2'b10;

   logic        clk;
   logic        rst;
   logic        s_awvalid;
   logic        s_awready;
   logic [11:0] s_awaddr;
   logic        s_wvalid;
   logic        s_wready;
   logic [31:0] s_wdata;
   logic [3:0]  s_wstrb;
   logic        s_bvalid;
   logic        s_bready;
   logic [1:0]  s_bresp;
   logic        s_arvalid;
   logic        s_arready;
   logic [11:0] s_araddr;
   logic        s_rvalid;
   logic        s_rready;
   logic [31:0] s_rdata;
   logic [1:0]  s_rresp;
   logic        irq;

   logic [31:0] model_sram [256];
   logic [31:0] model_rf [32];
   bit          stress;                // random low stretches on the readies
   int          irq_count = 0;
   int          ops_accepted;

   xfer_top dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // irq pulses seen at the top port
   always @(posedge clk) begin
      if (rst && irq)
         irq_count <= irq_count + 1;
   end

   initial begin
      #(4_000_000);
      $display("simulation ran past its time limit");
      $display("ERRORS FOUND");
      $fatal(1, "watchdog expired");
   end

   function automatic logic [31:0] expect_word(input bit from_rf, input int addr);
      if (from_rf)
         return model_rf[5'(addr)];
      return model_sram[8'(addr)];
   endfunction

   // apply an accepted operation to the model
   function automatic void model_op(input xfer_op_e op, input int blk);
      int i;
      case (op)
         OP_FILL:
            for (i = 0; i < 256; i++)
               model_sram[8'(i)] = ~{24'd0, 8'(i)};   // inverse of address
         OP_LOAD:
            for (i = 0; i < 32; i++)
               model_rf[5'(i)] = model_sram[8'(32 * blk + i)];
         OP_STORE:
            for (i = 0; i < 32; i++)
               model_sram[8'(STORE_BASE + 32 * blk + i)] = model_rf[5'(i)];   // wraps
         default: ;
      endcase
   endfunction

   function automatic logic pick_ready();
      if (!stress)
         return 1'b1;
      return ($urandom % 4) != 0;     // low about a quarter of the time
   endfunction

   task automatic check_data(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         $display("ERRORS FOUND");
         $fatal(1, "data check failed");
      end
   endtask

   task automatic check_resp(input string name, input logic [1:0] got,
                             input logic [1:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         $display("ERRORS FOUND");
         $fatal(1, "response check failed");
      end
   endtask

   task automatic check_op(input string name, input xfer_op_e got, input xfer_op_e exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         $display("ERRORS FOUND");
         $fatal(1, "opcode check failed");
      end
   endtask

   task automatic timed_out(input string what);
      $display("timeout, %s never came", what);
      $display("ERRORS FOUND");
      $fatal(1, "wait loop timed out");
   endtask

   task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      int n;
      bit hs;
      @(posedge clk);
      s_awvalid <= 1'b1;
      s_awaddr  <= addr;
      s_wvalid  <= 1'b1;
      s_wdata   <= data;
      s_bready  <= pick_ready();
      n = 0;
      do begin
         @(posedge clk);
         n++;
         if (n > TIMEOUT)
            timed_out("awready or wready");
      end while (!(s_awready || s_wready));
      check_data("s_awready", 32'(s_awready), 32'd1);   // both readies rise together
      check_data("s_wready", 32'(s_wready), 32'd1);
      s_awvalid <= 1'b0;
      s_wvalid  <= 1'b0;
      n = 0;
      do begin
         @(posedge clk);
         n++;
         if (n > TIMEOUT)
            timed_out("write response");
         hs = s_bvalid && s_bready;
         s_bready <= pick_ready();
      end while (!hs);
      resp = s_bresp;
   endtask

   task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      int n;
      bit hs;
      @(posedge clk);
      s_arvalid <= 1'b1;
      s_araddr  <= addr;
      s_rready  <= pick_ready();
      n = 0;
      do begin
         @(posedge clk);
         n++;
         if (n > TIMEOUT)
            timed_out("arready");
      end while (!s_arready);
      s_arvalid <= 1'b0;
      n = 0;
      do begin
         @(posedge clk);
         n++;
         if (n > TIMEOUT)
            timed_out("read data");
         hs = s_rvalid && s_rready;
         s_rready <= pick_ready();
      end while (!hs);
      data = s_rdata;
      resp = s_rresp;
   endtask

   task automatic start_op(input xfer_op_e op, input logic [1:0] blk,
                           input logic [1:0] exp_resp);
      logic [1:0] resp;
      axi_write(CTRL_OFS, {28'd0, blk, op}, resp);
      check_resp("bresp CTRL", resp, exp_resp);
      if (resp == OKAY) begin
         ops_accepted++;
         model_op(op, int'(blk));
      end
   endtask

   // poll STATUS until busy drops, then one irq per accepted op
   task automatic wait_idle();
      logic [31:0] d;
      logic [1:0]  resp;
      int          n;
      n = 0;
      do begin
         axi_read(STATUS_OFS, d, resp);
         check_resp("rresp STATUS", resp, OKAY);
         n++;
         if (n > 200)
            timed_out("busy low");
      end while (d[0]);
      check_data("irq_count", 32'(irq_count), 32'(ops_accepted));
   endtask

   task automatic check_status(input xfer_op_e exp_op);
      logic [31:0] d;
      logic [1:0]  resp;
      axi_read(STATUS_OFS, d, resp);
      check_resp("rresp STATUS", resp, OKAY);
      check_data("STATUS busy", {31'd0, d[0]}, 32'd0);
      check_op("STATUS last_op", xfer_op_e'(d[3:2]), exp_op);
   endtask

   task automatic check_peek(input logic [7:0] addr);
      logic [31:0] d;
      logic [1:0]  resp;
      axi_write(PEEK_ADDR_OFS, {24'd0, addr}, resp);
      check_resp("bresp PEEK_ADDR", resp, OKAY);
      axi_read(PEEK_DATA_OFS, d, resp);
      check_resp("rresp PEEK_DATA", resp, OKAY);
      check_data("PEEK_DATA", d, expect_word(1'b0, int'(addr)));
   endtask

   task automatic check_window();
      logic [31:0] d;
      logic [1:0]  resp;
      int          i;
      for (i = 0; i < 32; i++) begin
         axi_read(RF_WIN_OFS + 12'(4 * i), d, resp);
         check_resp("rresp RF window", resp, OKAY);
         check_data("RF window", d, expect_word(1'b1, i));
      end
   endtask

   task automatic check_store_block(input logic [1:0] blk);
      int i;
      for (i = 0; i < 32; i++)
         check_peek(8'(STORE_BASE + 32 * int'(blk) + i));
   endtask

   initial begin
      logic [31:0] d;
      logic [1:0]  resp;
      logic [1:0]  b;
      logic [1:0]  c;
      logic [7:0]  a;
      int          i;
      void'($urandom(44));
      rst          = 1'b0;
      s_awvalid    = 1'b0;
      s_awaddr     = '0;
      s_wvalid     = 1'b0;
      s_wdata      = '0;
      s_wstrb      = 4'hf;      // full words only
      s_bready     = 1'b0;
      s_arvalid    = 1'b0;
      s_araddr     = '0;
      s_rready     = 1'b0;
      stress       = 1'b0;
      ops_accepted = 0;
      repeat (8) @(posedge clk);
      rst <= 1'b1;

      // fill, then random peeks
      start_op(OP_FILL, 2'd0, OKAY);
      wait_idle();
      check_status(OP_FILL);
      for (i = 0; i < 16; i++) begin
         a = 8'($urandom % 256);
         check_peek(a);
      end

      // load block b, window must hold the inverted addresses
      b = 2'($urandom % 4);
      start_op(OP_LOAD, b, OKAY);
      wait_idle();
      for (i = 0; i < 32; i++) begin
         axi_read(RF_WIN_OFS + 12'(4 * i), d, resp);
         check_resp("rresp RF window", resp, OKAY);
         check_data("RF window", d, ~{24'd0, 8'(32 * int'(b) + i)});
      end

      c = 2'($urandom % 4);
      start_op(OP_STORE, c, OKAY);
      wait_idle();
      check_store_block(c);

      // store while a load runs is refused, so is OP_NONE
      start_op(OP_LOAD, b + 2'd1, OKAY);
      start_op(OP_STORE, c, SLVERR);
      wait_idle();
      start_op(OP_NONE, 2'd0, SLVERR);
      check_status(OP_LOAD);
      check_window();
      check_store_block(c);     // still the earlier store

      // back-pressure on both responses, peek issued during a load
      stress = 1'b1;
      b = 2'($urandom % 4);
      start_op(OP_LOAD, b, OKAY);
      a = 8'($urandom % 256);
      check_peek(a);
      wait_idle();
      check_window();
      c = 2'($urandom % 4);
      start_op(OP_STORE, c, OKAY);
      wait_idle();
      check_store_block(c);
      for (i = 0; i < 8; i++) begin
         a = 8'($urandom % 256);
         check_peek(a);
      end
      axi_read(PEEK_ADDR_OFS, d, resp);
      check_resp("rresp PEEK_ADDR", resp, OKAY);
      check_data("PEEK_ADDR", d, {24'd0, a});

      // read-only and unmapped offsets
      axi_write(STATUS_OFS, 32'd0, resp);
      check_resp("bresp STATUS", resp, SLVERR);
      axi_write(PEEK_DATA_OFS, 32'd0, resp);
      check_resp("bresp PEEK_DATA", resp, SLVERR);
      axi_read(12'h010, d, resp);
      check_resp("rresp unmapped", resp, SLVERR);
      stress = 1'b0;
      repeat (4) @(posedge clk);

      if (irq_count != ops_accepted) begin
         $display("Mismatch irq_count: got %h expected %h", irq_count, ops_accepted);
         $display("ERRORS FOUND");
         $fatal(1, "irq count wrong at end of run");
      end else begin
         $display("NO ERRORS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: flist.f
verilog/xfer_pkg.sv
verilog/reg_file.sv
verilog/block_sram.sv
verilog/xfer_csr.sv
verilog/xfer_sequencer.sv
verilog/xfer_top.sv
sim/xfer_asserts.sv
sim/xfer_tb.sv

// File: Makefile
# Verilator build and run of the data mover testbench
VERILATOR ?= verilator
TOP       ?= xfer_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
